// ==== dv/tcdm_cases.txt ====
# phase init op addr data be, with addr, data and be in hex; phase is en, hold or clr
# init 2 requests both initiators; initiator 1 then uses addr+1 and inverted data
en   0 w 10 11223344 f
en   1 w 11 a5a5a5a5 f
en   0 r 10 00000000 0
en   1 r 11 00000000 0
en   0 w 10 deadbeef 3
en   1 r 10 00000000 0
en   2 w 20 cafef00d f
en   2 r 20 00000000 0
en   1 w 30 01020304 f
en   0 w 30 ffffffff c
en   1 r 30 00000000 0
en   2 r 10 00000000 0
hold 0 r 30 00000000 0
hold 1 r 20 00000000 0
hold 0 w 40 12345678 f
clr  1 r 21 00000000 0
hold 1 r 11 00000000 0
en   1 r 21 00000000 0
en   1 w 40 9abcdef0 6
en   0 r 40 00000000 0
en   2 w 50 0badc0de f
en   2 r 50 00000000 0
en   0 r 51 00000000 0

// ==== dv/tcdm_subsystem_tb.sv ====
// Testbench for the two-initiator TCDM path, run from the project root.
// Stimulus comes from dv/tcdm_cases.txt; a case line with initiator 2 requests both at once.
// Bank words are not reset, so the cases write a word before they read it back.

`include "tcdm_config.svh"

module tcdm_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;

  localparam int CLK_PERIOD = 8;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               clear_i;
  logic               enable_i;
  logic  [N_INIT-1:0] init_req;
  addr_t [N_INIT-1:0] init_add;
  logic  [N_INIT-1:0] init_wen;
  be_t   [N_INIT-1:0] init_be;
  data_t [N_INIT-1:0] init_data;
  logic  [N_INIT-1:0] init_gnt;
  logic  [N_INIT-1:0] init_r_valid;
  data_t [N_INIT-1:0] init_r_data;

  logic [63:0] c_phase [$]; // one entry per case line.
  int          c_who   [$];
  logic        c_read  [$];
  addr_t       c_add   [$];
  data_t       c_data  [$];
  be_t         c_be    [$];
  bit          cases_loaded = 1'b0;

  data_t shadow [BANK_WORDS]; // expected bank contents.
  int    rr_ptr    = 0;        // initiator that wins the next tie.
  int    tag       = 0;        // expected user register in the filter.
  logic  resp_due  = 1'b0;     // a read response is due this cycle.
  int    resp_init = 0;        // initiator that should see it.
  data_t resp_data;

  tcdm_subsystem dut_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // ############################################################
  // error handling and case loading
  // ############################################################

  task automatic end_in_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error.");
  endtask

  task automatic value_error(input string msg);
    $display("FAIL @ %0t: %s", $time, msg);
    end_in_failure();
  endtask

  task automatic load_cases();
    int          fd;
    string       line;
    logic [63:0] phase;
    logic [7:0]  op;
    int          who;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] b;
    fd = $fopen("dv/tcdm_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/tcdm_cases.txt for reading.");
      end_in_failure();
    end else begin
      while (!$feof(fd)) begin
        // comment lines start with a hash and are skipped.
        if ($fgets(line, fd) > 1 && line.substr(0, 0) != "#" &&
            $sscanf(line, "%s %d %s %h %h %h", phase, who, op, a, d, b) == 6) begin
          c_phase.push_back(phase);
          c_who.push_back(who);
          c_read.push_back(op == "r"); // wen high means read.
          c_add.push_back(addr_t'(a));
          c_data.push_back(data_t'(d));
          c_be.push_back(be_t'(b));
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_request(input int k, input logic rd, input addr_t a, input data_t d,
                               input be_t b);
    init_req[k]  = 1'b1;
    init_wen[k]  = rd;
    init_add[k]  = a;
    init_data[k] = d;
    init_be[k]   = b;
  endtask

  // ############################################################
  // one clock cycle of checking and model update
  // ############################################################

  task automatic run_cycle();
    int    winner;
    logic  exp_valid;
    addr_t a;
    winner = -1;
    @(negedge clk_i); // outputs are settled mid-cycle.
    for (int k = 0; k < 2; k++) begin
      exp_valid = resp_due && (resp_init == k); // responses follow the filter tag.
      assert (init_r_valid[k] === exp_valid)
        else value_error($sformatf("initiator %0d r_valid %b, expected %b", k,
                                   init_r_valid[k], exp_valid));
      if (resp_due) begin
        // read data is broadcast, so every initiator must show it.
        assert (init_r_data[k] === resp_data)
          else value_error($sformatf("initiator %0d read %h, expected %h", k,
                                     init_r_data[k], resp_data));
      end
    end
    // the favoured initiator wins a tie, otherwise any single requester wins.
    if (init_req[rr_ptr]) winner = rr_ptr;
    else if (init_req[1 - rr_ptr]) winner = 1 - rr_ptr;
    for (int k = 0; k < 2; k++) begin
      assert (init_gnt[k] === (winner == k))
        else value_error($sformatf("initiator %0d gnt %b, expected %b", k, init_gnt[k],
                                   winner == k));
    end
    @(posedge clk_i);
    resp_due = 1'b0;
    if (winner >= 0) begin
      a = init_add[winner];
      if (init_wen[winner]) begin
        resp_due  = 1'b1;
        resp_data = shadow[a];
      end else begin
        for (int j = 0; j < int'(BE_W); j++) begin
          if (init_be[winner][j]) shadow[a][8*j +: 8] = init_data[winner][8*j +: 8];
        end
      end
      rr_ptr = 1 - winner; // priority passes to the other initiator.
    end
    if (clear_i) tag = 0;
    else if (enable_i && winner >= 0) tag = winner;
    resp_init = tag;
    #1;
    if (winner >= 0) init_req[winner] = 1'b0; // accepted, so the request is dropped.
  endtask

  // ############################################################
  // main sequence and watchdog
  // ############################################################

  initial begin
    int gap;
    void'($urandom(32'hdabd8329));
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    enable_i  = 1'b1;
    init_req  = '0;
    init_add  = '0;
    init_wen  = '0;
    init_be   = '0;
    init_data = '0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    foreach (c_who[i]) begin
      gap = int'($urandom % 4); // idle cycles between operations.
      repeat (gap) run_cycle();
      case (c_phase[i])
        "en":   enable_i = 1'b1;
        "hold": enable_i = 1'b0;
        "clr": begin
          enable_i = 1'b0;
          clear_i  = 1'b1; // one idle cycle with the clear pulse.
          run_cycle();
          clear_i  = 1'b0;
        end
        default: begin
          $display("unknown phase tag on case %0d.", i + 1);
          end_in_failure();
        end
      endcase
      if (c_who[i] == 2) begin
        drive_request(0, c_read[i], c_add[i], c_data[i], c_be[i]);
        drive_request(1, c_read[i], c_add[i] + 1'b1, ~c_data[i], c_be[i]);
      end else begin
        drive_request(c_who[i], c_read[i], c_add[i], c_data[i], c_be[i]);
      end
      while (init_req != '0) run_cycle(); // wait until every request is granted.
    end
    repeat (2) run_cycle(); // the last read response.
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    int limit_cycles;
    wait (cases_loaded);
    limit_cycles = c_who.size() * 10 + 10; // ten cycles per case plus reset.
    #(limit_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not complete.", limit_cycles);
    end_in_failure();
  end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/tcdm_pkg.sv
rtl/tcdm_init_arbiter.sv
rtl/tcdm_r_user_filter.sv
rtl/tcdm_bank.sv
rtl/tcdm_subsystem.sv
dv/tcdm_subsystem_tb.sv

// ==== include/tcdm_config.svh ====
// Build-time sizes of the TCDM path.
// TCDM_BANK_WORDS must equal 2**TCDM_ADDR_W, since the bank decodes the full word address.
// TCDM_DATA_W must be a multiple of 8, one byte enable per data byte.

`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// ############################################################
// address and data
// ############################################################

`define TCDM_ADDR_W 8 // word address, not byte address.

`define TCDM_DATA_W 32 // one bank word.

// ############################################################
// topology
// ############################################################

`define TCDM_N_INIT 2 // initiators sharing the bank.

`define TCDM_BANK_WORDS 256 // depth of the single bank.

`endif

// ==== rtl/tcdm_bank.sv ====
// Single-port TCDM bank, one word per address, with byte-enabled writes.
// Every request is granted in its own cycle and the bank never stalls.
// A read is answered one cycle later; a write gives no response.
// Memory contents are undefined after reset.

module tcdm_bank (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req,
  input  tcdm_pkg::addr_t add,
  input  logic            wen,  // high for a read, low for a write.
  input  tcdm_pkg::be_t   be,
  input  tcdm_pkg::data_t data,
  output logic            gnt,
  output logic            r_valid,
  output tcdm_pkg::data_t r_data
);

  import tcdm_pkg::*;

  data_t mem [BANK_WORDS]; // the storage array.
  logic  rd_en;            // granted read this cycle.
  logic  wr_en;            // granted write this cycle.

  // ############################################################
  // grant
  // ############################################################

  // the bank is always free, so the grant simply mirrors the request.
  assign gnt = req;

  assign rd_en = req && gnt && wen;
  assign wr_en = req && gnt && !wen;

  // ############################################################
  // storage and read data
  // ############################################################

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < int'(BE_W); b++) begin
        if (be[b]) begin
          mem[add][8*b +: 8] <= data[8*b +: 8]; // only enabled bytes change.
        end
      end
    end
    if (rd_en) begin
      r_data <= mem[add]; // held until the next read.
    end
  end

  // ############################################################
  // response strobe
  // ############################################################

  // one-cycle pulse that marks r_data as the answer to the last read.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= rd_en;
    end
  end

endmodule

// ==== rtl/tcdm_init_arbiter.sv ====
// Round-robin arbiter for N_INIT initiators onto one TCDM port.
// Grants are combinational on out_gnt, so the downstream port must not wait on gnt.
// Responses are routed only by out_r_user, which must come back one cycle after the grant.

module tcdm_init_arbiter #(
  parameter int unsigned N_INIT = tcdm_pkg::N_INIT
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // initiator side, one slice per initiator.
  input  logic             [N_INIT-1:0]      init_req,
  input  tcdm_pkg::addr_t  [N_INIT-1:0]      init_add,
  input  logic             [N_INIT-1:0]      init_wen,
  input  tcdm_pkg::be_t    [N_INIT-1:0]      init_be,
  input  tcdm_pkg::data_t  [N_INIT-1:0]      init_data,
  output logic             [N_INIT-1:0]      init_gnt,
  output logic             [N_INIT-1:0]      init_r_valid,
  output tcdm_pkg::data_t  [N_INIT-1:0]      init_r_data,
  // shared port toward the filter.
  output logic                               out_req,
  output tcdm_pkg::addr_t                    out_add,
  output logic                               out_wen,
  output tcdm_pkg::be_t                      out_be,
  output tcdm_pkg::data_t                    out_data,
  output tcdm_pkg::user_t                    out_user,
  input  logic                               out_gnt,
  input  logic                               out_r_valid,
  input  tcdm_pkg::data_t                    out_r_data,
  input  tcdm_pkg::user_t                    out_r_user
);

  import tcdm_pkg::*;

  user_t ptr_q;    // initiator with the highest priority this cycle.
  user_t winner;   // initiator picked this cycle.
  user_t next_ptr; // priority after the winner is accepted.
  logic  found;    // some initiator is requesting.

  // ############################################################
  // request selection
  // ############################################################

  // scan from ptr_q upward and take the first requester.
  always_comb begin
    int unsigned idx;
    winner = ptr_q;
    found  = 1'b0;
    for (int i = 0; i < int'(N_INIT); i++) begin
      idx = (int'(ptr_q) + i) % N_INIT;
      if (!found && init_req[idx]) begin
        winner = user_t'(idx);
        found  = 1'b1;
      end
    end
  end

  // the initiator after the winner gets the top priority next.
  assign next_ptr = (winner == user_t'(N_INIT - 1)) ? '0 : winner + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0; // initiator 0 goes first after reset.
    end else if (out_req && out_gnt) begin
      ptr_q <= next_ptr; // rotate only on an accepted request.
    end
  end

  assign out_req  = found;
  assign out_add  = init_add[winner];
  assign out_wen  = init_wen[winner];
  assign out_be   = init_be[winner];
  assign out_data = init_data[winner];
  assign out_user = winner; // the tag that the filter hands back as r_user.

  // ############################################################
  // grant and response routing
  // ############################################################

  always_comb begin
    for (int k = 0; k < int'(N_INIT); k++) begin
      init_gnt[k]     = out_gnt && found && (winner == user_t'(k)); // winner only.
      init_r_valid[k] = out_r_valid && (out_r_user == user_t'(k));  // steer by tag.
      init_r_data[k]  = out_r_data; // data is broadcast, r_valid qualifies it.
    end
  end

  // two initiators must never both see their request taken in one cycle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(init_gnt))
    else $error("more than one initiator granted in the same cycle.");

endmodule

// ==== rtl/tcdm_pkg.sv ====
// Shared types of the TCDM path, all derived from the config macros.
// The user tag is sized to hold an initiator index, with at least one bit.

`include "tcdm_config.svh"

package tcdm_pkg;

  // sizes taken over from the config header.
  localparam int unsigned N_INIT     = `TCDM_N_INIT;
  localparam int unsigned BANK_WORDS = `TCDM_BANK_WORDS;
  localparam int unsigned BE_W       = `TCDM_DATA_W / 8; // one enable per byte.

  // one bit for two initiators, more only if the topology grows.
  localparam int unsigned USER_W = (N_INIT > 1) ? $clog2(N_INIT) : 1;

  // word address into the bank.
  typedef logic [`TCDM_ADDR_W-1:0] addr_t;

  // one data word.
  typedef logic [`TCDM_DATA_W-1:0] data_t;

  // byte enables, bit b covers data bits 8*b+7 down to 8*b.
  typedef logic [BE_W-1:0] be_t;

  // initiator index carried with a request and returned as r_user.
  typedef logic [USER_W-1:0] user_t;

endpackage

// ==== rtl/tcdm_r_user_filter.sv ====
// Strips the user tag from a TCDM request and returns it as r_user on the response.
// Only correct where a granted read is answered in exactly the next cycle.
// Holds one tag, so at most one read may be outstanding.

module tcdm_r_user_filter (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,
  input  logic            enable_i,
  // target side, facing the arbiter.
  input  logic            tgt_req,
  input  tcdm_pkg::addr_t tgt_add,
  input  logic            tgt_wen,
  input  tcdm_pkg::be_t   tgt_be,
  input  tcdm_pkg::data_t tgt_data,
  input  tcdm_pkg::user_t tgt_user,
  output logic            tgt_gnt,
  output logic            tgt_r_valid,
  output tcdm_pkg::data_t tgt_r_data,
  output tcdm_pkg::user_t tgt_r_user,
  // initiator side, facing the bank.
  output logic            ini_req,
  output tcdm_pkg::addr_t ini_add,
  output logic            ini_wen,
  output tcdm_pkg::be_t   ini_be,
  output tcdm_pkg::data_t ini_data,
  input  logic            ini_gnt,
  input  logic            ini_r_valid,
  input  tcdm_pkg::data_t ini_r_data
);

  import tcdm_pkg::*;

  user_t user_q; // tag of the last request seen while enabled.

  // the request goes on untouched, without its tag.
  assign ini_req  = tgt_req;
  assign ini_add  = tgt_add;
  assign ini_wen  = tgt_wen;
  assign ini_be   = tgt_be;
  assign ini_data = tgt_data;

  assign tgt_gnt     = ini_gnt;
  assign tgt_r_valid = ini_r_valid;
  assign tgt_r_data  = ini_r_data;
  assign tgt_r_user  = user_q; // valid in the cycle after the request.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear_i) begin
      user_q <= '0; // routes the next responses to initiator 0.
    end else if (enable_i && tgt_req) begin
      user_q <= tgt_user;
    end
  end

  // a granted read must be answered in the very next cycle.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (ini_gnt && ini_wen) |=> ini_r_valid)
    else $error("read response not one cycle after grant, r_user would be stale.");

  // without a grant there must be no response in the next cycle.
  assert property (@(posedge clk_i) disable iff (!rst_ni) !ini_gnt |=> !ini_r_valid)
    else $error("response without a grant one cycle earlier, r_user is misaligned.");

endmodule

// ==== rtl/tcdm_subsystem.sv ====
// Two initiators sharing one TCDM bank through an arbiter and an r_user filter.
// Reads have a fixed latency of one cycle; writes complete on the grant.
// clear_i and enable_i act on the filter tag only, and so change response routing.

module tcdm_subsystem (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic                                  enable_i,
  input  logic             [tcdm_pkg::N_INIT-1:0] init_req,
  input  tcdm_pkg::addr_t  [tcdm_pkg::N_INIT-1:0] init_add,
  input  logic             [tcdm_pkg::N_INIT-1:0] init_wen,
  input  tcdm_pkg::be_t    [tcdm_pkg::N_INIT-1:0] init_be,
  input  tcdm_pkg::data_t  [tcdm_pkg::N_INIT-1:0] init_data,
  output logic             [tcdm_pkg::N_INIT-1:0] init_gnt,
  output logic             [tcdm_pkg::N_INIT-1:0] init_r_valid,
  output tcdm_pkg::data_t  [tcdm_pkg::N_INIT-1:0] init_r_data
);

  import tcdm_pkg::*;

  // ############################################################
  // arbiter to filter
  // ############################################################

  logic  arb_req;
  addr_t arb_add;
  logic  arb_wen;
  be_t   arb_be;
  data_t arb_data;
  user_t arb_user;    // winner index.
  logic  arb_gnt;
  logic  arb_r_valid;
  data_t arb_r_data;
  user_t arb_r_user;  // tag handed back by the filter.

  // ############################################################
  // filter to bank
  // ############################################################

  logic  bank_req;
  addr_t bank_add;
  logic  bank_wen;
  be_t   bank_be;
  data_t bank_data;
  logic  bank_gnt;
  logic  bank_r_valid;
  data_t bank_r_data;

  tcdm_init_arbiter #(
    .N_INIT (N_INIT)
  ) arbiter_i (
    .clk_i, .rst_ni,
    .init_req, .init_add, .init_wen, .init_be, .init_data,
    .init_gnt, .init_r_valid, .init_r_data,
    .out_req     (arb_req),     .out_add    (arb_add),     .out_wen  (arb_wen),
    .out_be      (arb_be),      .out_data   (arb_data),    .out_user (arb_user),
    .out_gnt     (arb_gnt),     .out_r_valid(arb_r_valid),
    .out_r_data  (arb_r_data),  .out_r_user (arb_r_user)
  );

  // placed right in front of the bank, where read latency is exactly one cycle.
  tcdm_r_user_filter filter_i (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .tgt_req     (arb_req),     .tgt_add    (arb_add),     .tgt_wen  (arb_wen),
    .tgt_be      (arb_be),      .tgt_data   (arb_data),    .tgt_user (arb_user),
    .tgt_gnt     (arb_gnt),     .tgt_r_valid(arb_r_valid),
    .tgt_r_data  (arb_r_data),  .tgt_r_user (arb_r_user),
    .ini_req     (bank_req),    .ini_add    (bank_add),    .ini_wen  (bank_wen),
    .ini_be      (bank_be),     .ini_data   (bank_data),
    .ini_gnt     (bank_gnt),    .ini_r_valid(bank_r_valid), .ini_r_data(bank_r_data)
  );

  tcdm_bank bank_i (
    .clk_i, .rst_ni,
    .req  (bank_req),  .add (bank_add),  .wen (bank_wen),
    .be   (bank_be),   .data(bank_data),
    .gnt  (bank_gnt),  .r_valid(bank_r_valid), .r_data(bank_r_data)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the TCDM testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tcdm_subsystem_tb -o tcdm_sim

./obj_dir/tcdm_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run.sh: test passed"
  exit 0
else
  echo "run.sh: test failed"
  exit 1
fi
